// ==== flist.f ====
verilog/mul16_pkg.sv
verilog/cla_adder32.sv
verilog/array_mult8.sv
verilog/operand_splitter.sv
verilog/product_assembler.sv
verilog/mul16_top.sv
dv/mul16_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the multiplier testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

verilator --binary --timing -Wno-fatal -f flist.f --top-module mul16_tb -o mul16_sim
if [ $? -ne 0 ]; then
  echo "Verilator build did not complete"
  exit 1
fi

output=$(./obj_dir/mul16_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
  exit 0
else
  echo "Pass line not found in simulator output"
  exit 1
fi

// ==== dv/mul16_tb.sv ====
module mul16_tb;

  localparam int CLK_HALF     = 50;
  localparam int RESET_CYCLES = 10;
  localparam int RANDOM_PAIRS = 300;
  localparam int CORNERS      = 8;
  // Tests take roughly 1500 cycles
  localparam int MAX_CYCLES   = 4000;

  logic        clk;
  logic        reset;
  logic        in_valid;
  logic        in_ready;
  logic [15:0] a;
  logic [15:0] b;
  logic        out_valid;
  logic        out_ready;
  logic [31:0] product;

  integer      seed;
  int          cycle_count = 0;
  string       test_name;

  // Products of accepted pairs, oldest first
  logic [31:0] expected_q [$];
  int          results_seen;
  logic        took_input;
  logic        cycle_out_valid;
  logic        cycle_in_ready;
  logic        hold_pending;
  logic [31:0] held_product;

  logic [15:0] corner_a [CORNERS] = '{16'h0000, 16'h0001, 16'hffff, 16'h8000,
                                      16'h00ff, 16'hff00, 16'h00ff, 16'hff00};
  logic [15:0] corner_b [CORNERS] = '{16'h0000, 16'hffff, 16'hffff, 16'h8000,
                                      16'h00ff, 16'h00ff, 16'hff00, 16'hff00};

  mul16_top i_mul16_top (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .product   (product)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles in %s", cycle_count, test_name);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] model_product(logic [15:0] x, logic [15:0] y);
    return {16'h0000, x} * {16'h0000, y};
  endfunction

  task automatic check_equal(string what, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED %s %s: expected %h, actual %h",
               test_name, what, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // One rising edge, handshakes judged on the values before it
  task automatic clock_cycle();
    @(posedge clk);
    cycle_out_valid = out_valid;
    cycle_in_ready  = in_ready;
    took_input      = in_valid && in_ready;
    if (took_input) begin
      expected_q.push_back(model_product(a, b));
    end
    if (hold_pending) begin
      check_equal("held out_valid", 32'd1, 32'(out_valid));
      check_equal("held product", held_product, product);
    end
    if (out_valid && !out_ready) begin
      check_equal("in_ready under stall", 32'd0, 32'(in_ready));
    end
    if (out_valid && out_ready) begin
      assert (expected_q.size() != 0) else begin
        $display("A result came out with no pair outstanding in %s", test_name);
        $display("Simulation failed");
        $fatal(1);
      end
      check_equal("product", expected_q.pop_front(), product);
      results_seen++;
    end
    hold_pending = out_valid && !out_ready;
    held_product = product;
  endtask

  task automatic drain_results();
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    while (expected_q.size() != 0) begin
      clock_cycle();
    end
    // Pipeline is three deep, so a duplicate result would show by now
    repeat (3) begin
      clock_cycle();
    end
  endtask

  task automatic test_reset();
    test_name = "test_reset";
    clock_cycle();
    check_equal("out_valid", 32'd0, 32'(cycle_out_valid));
    check_equal("in_ready", 32'd1, 32'(cycle_in_ready));
  endtask

  task automatic test_latency();
    int start_count;
    test_name   = "test_latency";
    start_count = results_seen;
    out_ready <= 1'b1;
    a         <= 16'h1234;
    b         <= 16'habcd;
    in_valid  <= 1'b1;
    clock_cycle();
    check_equal("accepted", 32'd1, 32'(took_input));
    in_valid <= 1'b0;
    repeat (2) begin
      clock_cycle();
      check_equal("early out_valid", 32'd0, 32'(cycle_out_valid));
    end
    // Result registered at N+2, taken on edge N+3
    clock_cycle();
    check_equal("out_valid", 32'd1, 32'(cycle_out_valid));
    check_equal("result count", 32'(start_count + 1), 32'(results_seen));
  endtask

  task automatic test_corners();
    int start_count;
    test_name   = "test_corners";
    start_count = results_seen;
    out_ready <= 1'b1;
    for (int i = 0; i < CORNERS; i++) begin
      a        <= corner_a[i];
      b        <= corner_b[i];
      in_valid <= 1'b1;
      clock_cycle();
      check_equal("accepted", 32'd1, 32'(took_input));
    end
    drain_results();
    check_equal("result count", 32'(start_count + CORNERS), 32'(results_seen));
  endtask

  task automatic test_stream();
    int          start_count;
    logic [31:0] rnd;
    test_name   = "test_stream";
    start_count = results_seen;
    out_ready <= 1'b1;
    for (int i = 0; i < RANDOM_PAIRS; i++) begin
      rnd = $random(seed);
      a <= rnd[15:0];
      b <= rnd[31:16];
      in_valid <= 1'b1;
      clock_cycle();
      check_equal("in_ready", 32'd1, 32'(cycle_in_ready));
    end
    drain_results();
    check_equal("result count", 32'(start_count + RANDOM_PAIRS), 32'(results_seen));
  endtask

  task automatic test_backpressure();
    int          start_count;
    int          accepted;
    logic        offering;
    logic [31:0] rnd;
    test_name   = "test_backpressure";
    start_count = results_seen;
    accepted    = 0;
    offering    = 1'b0;
    while (accepted < RANDOM_PAIRS) begin
      clock_cycle();
      if (took_input) begin
        accepted++;
        offering = 1'b0;
      end
      // A pair stays on the inputs until it is taken
      if (!offering && accepted < RANDOM_PAIRS) begin
        rnd      = $random(seed);
        offering = rnd[0];
        rnd      = $random(seed);
        a <= rnd[15:0];
        b <= rnd[31:16];
      end
      in_valid <= offering;
      rnd = $random(seed);
      out_ready <= rnd[0];
    end
    drain_results();
    check_equal("result count", 32'(start_count + RANDOM_PAIRS), 32'(results_seen));
  endtask

  initial begin
    seed         = 32'h95cd;
    hold_pending = 1'b0;
    results_seen = 0;
    test_name    = "reset";
    reset        = 1'b1;
    in_valid     = 1'b0;
    a            = 16'h0000;
    b            = 16'h0000;
    out_ready    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    test_reset();
    test_latency();
    test_corners();
    test_stream();
    test_backpressure();

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== verilog/mul16_top.sv ====
module mul16_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                in_valid,
  output logic                in_ready,
  input  mul16_pkg::operand_t a,
  input  mul16_pkg::operand_t b,
  output logic                out_valid,
  input  logic                out_ready,
  output mul16_pkg::product_t product
);

  import mul16_pkg::*;

  // Pipeline-wide load enable, from the output stage
  logic           advance;

  quad_operands_t quad_ops     [QUADRANTS];
  quad_result_t   quad_results [QUADRANTS];

  operand_splitter i_operand_splitter (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .advance  (advance),
    .a        (a),
    .b        (b),
    .quad_ops (quad_ops)
  );

  // Same exact array for all four quadrants
  for (genvar i = 0; i < QUADRANTS; i++) begin : g_quadrant
    array_mult8 i_array_mult8 (
      .clk     (clk),
      .reset   (reset),
      .advance (advance),
      .ops     (quad_ops[i]),
      .result  (quad_results[i])
    );
  end

  product_assembler i_product_assembler (
    .clk       (clk),
    .reset     (reset),
    .results   (quad_results),
    .out_ready (out_ready),
    .advance   (advance),
    .out_valid (out_valid),
    .product   (product)
  );

  // Input side can take a pair whenever the pipeline moves
  assign in_ready = advance;

endmodule

// ==== verilog/product_assembler.sv ====
module product_assembler (
  input  logic                    clk,
  input  logic                    reset,
  input  mul16_pkg::quad_result_t results [mul16_pkg::QUADRANTS],
  input  logic                    out_ready,
  output logic                    advance,
  output logic                    out_valid,
  output mul16_pkg::product_t     product
);

  import mul16_pkg::*;

  product_t hh_ll;
  product_t lh_shifted;
  product_t hl_shifted;
  product_t partial_sum;
  product_t full_sum;

  // HH and LL do not overlap, so they just sit side by side
  assign hh_ll = {results[QUAD_HH].prod, results[QUAD_LL].prod};

  // Cross terms land one half up
  assign lh_shifted = {{HALF_W{1'b0}}, results[QUAD_LH].prod, {HALF_W{1'b0}}};
  assign hl_shifted = {{HALF_W{1'b0}}, results[QUAD_HL].prod, {HALF_W{1'b0}}};

  cla_adder32 i_cla_adder32_lh (
    .x   (hh_ll),
    .y   (lh_shifted),
    .sum (partial_sum)
  );

  cla_adder32 i_cla_adder32_hl (
    .x   (partial_sum),
    .y   (hl_shifted),
    .sum (full_sum)
  );

  // Whole pipeline moves when the output slot is free or draining
  assign advance = !out_valid || out_ready;

  // All quadrant valid bits move in lockstep, LL stands for them
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= results[QUAD_LL].valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      product <= full_sum;
    end
  end

endmodule

// ==== verilog/operand_splitter.sv ====
module operand_splitter (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      in_valid,
  input  logic                      advance,
  input  mul16_pkg::operand_t       a,
  input  mul16_pkg::operand_t       b,
  output mul16_pkg::quad_operands_t quad_ops [mul16_pkg::QUADRANTS]
);

  import mul16_pkg::*;

  operand_t a_q;
  operand_t b_q;
  logic     valid_q;
  half_t    a_lo;
  half_t    a_hi;
  half_t    b_lo;
  half_t    b_hi;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (advance) begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      a_q <= a;
      b_q <= b;
    end
  end

  assign a_lo = a_q[HALF_W-1:0];
  assign a_hi = a_q[OPERAND_W-1:HALF_W];
  assign b_lo = b_q[HALF_W-1:0];
  assign b_hi = b_q[OPERAND_W-1:HALF_W];

  // First letter is the half of a, second the half of b
  assign quad_ops[QUAD_LL] = '{a: a_lo, b: b_lo, valid: valid_q};
  assign quad_ops[QUAD_HL] = '{a: a_hi, b: b_lo, valid: valid_q};
  assign quad_ops[QUAD_LH] = '{a: a_lo, b: b_hi, valid: valid_q};
  assign quad_ops[QUAD_HH] = '{a: a_hi, b: b_hi, valid: valid_q};

endmodule

// ==== verilog/array_mult8.sv ====
module array_mult8 (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      advance,
  input  mul16_pkg::quad_operands_t ops,
  output mul16_pkg::quad_result_t   result
);

  import mul16_pkg::*;

  // Partial product row i holds a & b[i]
  half_t             pp        [HALF_W];
  half_t             sum_row   [HALF_W];
  logic [HALF_W-2:0] carry_row [1:HALF_W-1];
  logic [HALF_W-1:0] ripple_carry;
  quad_prod_t        prod;
  quad_prod_t        prod_q;
  logic              valid_q;

  always_comb begin
    for (int i = 0; i < HALF_W; i++) begin
      pp[i] = ops.a & {HALF_W{ops.b[i]}};
    end

    sum_row[0] = pp[0];

    // Row 1 has no incoming carries, so half adders
    for (int j = 0; j < HALF_W - 1; j++) begin
      sum_row[1][j]   = sum_row[0][j+1] ^ pp[1][j];
      carry_row[1][j] = sum_row[0][j+1] & pp[1][j];
    end
    sum_row[1][HALF_W-1] = pp[1][HALF_W-1];

    // Carry-save rows of full adders, carries kept in place
    for (int i = 2; i < HALF_W; i++) begin
      for (int j = 0; j < HALF_W - 1; j++) begin
        sum_row[i][j]   = sum_row[i-1][j+1] ^ pp[i][j] ^ carry_row[i-1][j];
        carry_row[i][j] = (sum_row[i-1][j+1] & pp[i][j]) |
                          (carry_row[i-1][j] & (sum_row[i-1][j+1] ^ pp[i][j]));
      end
      sum_row[i][HALF_W-1] = pp[i][HALF_W-1];
    end
  end

  // Low byte drops out of the array one bit per row
  always_comb begin
    for (int i = 0; i < HALF_W; i++) begin
      prod[i] = sum_row[i][0];
    end

    // Ripple row merges the last sums and carries into the high byte
    ripple_carry[0] = 1'b0;
    for (int j = 0; j < HALF_W - 1; j++) begin
      prod[HALF_W+j]    = sum_row[HALF_W-1][j+1] ^ carry_row[HALF_W-1][j] ^ ripple_carry[j];
      ripple_carry[j+1] = (sum_row[HALF_W-1][j+1] & carry_row[HALF_W-1][j]) |
                          (ripple_carry[j] &
                           (sum_row[HALF_W-1][j+1] ^ carry_row[HALF_W-1][j]));
    end
    prod[2*HALF_W-1] = ripple_carry[HALF_W-1];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (advance) begin
      valid_q <= ops.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      prod_q <= prod;
    end
  end

  assign result.valid = valid_q;
  assign result.prod  = prod_q;

endmodule

// ==== verilog/cla_adder32.sv ====
module cla_adder32 (
  input  mul16_pkg::product_t x,
  input  mul16_pkg::product_t y,
  output mul16_pkg::product_t sum
);

  import mul16_pkg::*;

  product_t               p;
  // Top bit generate would only feed a carry-out
  logic [PRODUCT_W-2:0]   g;
  // Group 0 has no carry-in, so its propagate term drops out
  logic [CLA_GROUPS-2:1]  group_prop;
  logic [CLA_GROUPS-2:0]  group_gen;
  logic [CLA_GROUPS-1:0]  group_carry;

  assign p = x ^ y;
  assign g = x[PRODUCT_W-2:0] & y[PRODUCT_W-2:0];

  always_comb begin
    int base;
    for (int k = 0; k < CLA_GROUPS - 1; k++) begin
      base = k * CLA_GROUP_W;
      group_gen[k] = g[base+3] |
                     (p[base+3] & g[base+2]) |
                     (p[base+3] & p[base+2] & g[base+1]) |
                     (p[base+3] & p[base+2] & p[base+1] & g[base]);
    end
    for (int k = 1; k < CLA_GROUPS - 1; k++) begin
      base = k * CLA_GROUP_W;
      group_prop[k] = &p[base +: CLA_GROUP_W];
    end
  end

  // Second level, every group carry-in straight from group P and G
  always_comb begin
    logic term;
    group_carry = '0;
    for (int k = 1; k < CLA_GROUPS; k++) begin
      for (int m = 0; m < k; m++) begin
        term = group_gen[m];
        for (int n = m + 1; n < k; n++) begin
          term = term & group_prop[n];
        end
        group_carry[k] = group_carry[k] | term;
      end
    end
  end

  for (genvar k = 0; k < CLA_GROUPS; k++) begin : g_group
    localparam int BASE = k * CLA_GROUP_W;
    logic [CLA_GROUP_W-1:0] c;

    assign c[0] = group_carry[k];
    assign c[1] = g[BASE] | (p[BASE] & c[0]);
    assign c[2] = g[BASE+1] | (p[BASE+1] & g[BASE]) | (p[BASE+1] & p[BASE] & c[0]);
    assign c[3] = g[BASE+2] |
                  (p[BASE+2] & g[BASE+1]) |
                  (p[BASE+2] & p[BASE+1] & g[BASE]) |
                  (p[BASE+2] & p[BASE+1] & p[BASE] & c[0]);

    assign sum[BASE +: CLA_GROUP_W] = p[BASE +: CLA_GROUP_W] ^ c;
  end

endmodule

// ==== verilog/mul16_pkg.sv ====
package mul16_pkg;

  // Operand and product widths
  localparam int OPERAND_W = 16;
  localparam int HALF_W    = 8;
  localparam int PRODUCT_W = 32;

  // Quadrant multipliers, named by which halves of a and b they take
  localparam int QUADRANTS = 4;
  localparam int QUAD_LL   = 0;
  localparam int QUAD_HL   = 1;
  localparam int QUAD_LH   = 2;
  localparam int QUAD_HH   = 3;

  // Two-level lookahead adder geometry
  localparam int CLA_GROUP_W = 4;
  localparam int CLA_GROUPS  = 8;

  typedef logic [OPERAND_W-1:0]   operand_t;
  typedef logic [HALF_W-1:0]      half_t;
  typedef logic [2*HALF_W-1:0]    quad_prod_t;
  typedef logic [PRODUCT_W-1:0]   product_t;

  // One quadrant job, splitter to multiplier
  typedef struct packed {
    half_t a;
    half_t b;
    logic  valid;
  } quad_operands_t;

  // One quadrant result, multiplier to assembler
  typedef struct packed {
    logic       valid;
    quad_prod_t prod;
  } quad_result_t;

endpackage
